/* src/sldu_defines.svh */
/*
 * Sizing macros for the vector slide unit.
 * Included by both packages and by every RTL module that sizes ports or storage.
 */
`ifndef SLDU_DEFINES_SVH
`define SLDU_DEFINES_SVH

// Lane organization
`define SLDU_NR_LANES 4
`define SLDU_ELEN 64
// One full VRF word spans all lanes
`define SLDU_WORD_BYTES (`SLDU_NR_LANES * 8)

// Queue depths
`define SLDU_INSN_QUEUE_DEPTH 2
`define SLDU_RESULT_QUEUE_DEPTH 2

// Instruction ids and field widths
`define SLDU_NR_VINSN 8
`define SLDU_VADDR_W 8
`define SLDU_VL_W 10
`define SLDU_WORDS_PER_REG 8

`endif

/* src/sldu_insn_pkg.sv */
/*
 * Instruction-side types of the slide unit.
 * Describes what the sequencer hands over: opcode, element width,
 * instruction id and the packed instruction record.
 */
`include "sldu_defines.svh"

package sldu_insn_pkg;

  // Slide direction
  typedef enum logic {
    VSLIDEUP,
    VSLIDEDOWN
  } sldu_op_e;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vsew_e;

  typedef logic [$clog2(`SLDU_NR_VINSN)-1:0] vid_t;

  // Stride is in elements from the sequencer, in bytes once queued
  typedef struct packed {
    vid_t                   id;
    sldu_op_e               op;
    vsew_e                  vsew;
    logic [`SLDU_VL_W-1:0]  vl;
    logic [`SLDU_VL_W:0]    stride;
    logic [4:0]             vd;
  } sldu_insn_t;

endpackage

/* src/sldu_lane_pkg.sv */
/*
 * Lane-side types of the slide unit.
 * Lane data word, byte strobe, VRF word address, byte counters and
 * the state encoding of the slide engine.
 */
`include "sldu_defines.svh"

package sldu_lane_pkg;

  typedef logic [`SLDU_ELEN-1:0]   elen_t;
  typedef logic [`SLDU_ELEN/8-1:0] strb_t;
  typedef logic [`SLDU_VADDR_W-1:0] vaddr_t;

  // Wide enough for vl times the largest element
  typedef logic [15:0] byte_cnt_t;

  // Slide engine FSM
  typedef enum logic {
    SLIDE_IDLE,
    SLIDE_RUN
  } slide_state_e;

endpackage

/* src/sldu_insn_queue.sv */
/*
 * Instruction queue of the slide unit.
 * Accepts instructions from the sequencer and keeps them until their last
 * result is committed. Issue and commit heads advance on their own, so one
 * instruction can drain its results while the next one is being issued.
 */
`timescale 1ns/10ps
`include "sldu_defines.svh"

module sldu_insn_queue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Sequencer side
  input  sldu_insn_pkg::sldu_insn_t insn_i,
  input  logic                      insn_valid_i,
  output logic                      insn_ready_o,
  // Slide engine side
  output sldu_insn_pkg::sldu_insn_t issue_insn_o,
  output logic                      issue_valid_o,
  input  logic                      issue_done_i,
  // Writeback side
  output sldu_insn_pkg::sldu_insn_t commit_insn_o,
  output logic                      commit_valid_o,
  input  logic                      commit_done_i
);
  import sldu_insn_pkg::*;

  localparam int unsigned Depth = `SLDU_INSN_QUEUE_DEPTH;
  localparam int unsigned PntW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth) + 1;

  sldu_insn_t      mem_q [Depth];
  sldu_insn_t      insn_conv;
  logic [PntW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Instructions waiting for issue and for commit
  logic [CntW-1:0] issue_cnt_q, commit_cnt_q;
  logic            accept;

  // Wrapping pointer increment
  function automatic logic [PntW-1:0] bump(input logic [PntW-1:0] pnt);
    return (pnt == PntW'(Depth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // An entry stays occupied until its commit finishes
  assign insn_ready_o = (commit_cnt_q != CntW'(Depth));
  assign accept       = insn_valid_i & insn_ready_o;

  // Slide offset in bytes inside the register
  always_comb begin
    insn_conv        = insn_i;
    insn_conv.stride = insn_i.stride << insn_i.vsew;
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= insn_conv;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept) accept_pnt_q <= bump(accept_pnt_q);
      if (issue_done_i) issue_pnt_q <= bump(issue_pnt_q);
      if (commit_done_i) commit_pnt_q <= bump(commit_pnt_q);
      issue_cnt_q  <= issue_cnt_q + CntW'(accept) - CntW'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + CntW'(accept) - CntW'(commit_done_i);
    end
  end

  // Heads, visible the cycle after acceptance
  assign issue_insn_o   = mem_q[issue_pnt_q];
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign commit_insn_o  = mem_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

endmodule

/* src/sldu_slide_engine.sv */
/*
 * Slide engine.
 * Walks an input pointer through the operand words delivered by the lanes
 * and an output pointer through the destination words. Each step moves as
 * many bytes as fit in both, packs them into a word and pushes the word to
 * the result queue once it is full or the instruction ends.
 */
`timescale 1ns/10ps
`include "sldu_defines.svh"

module sldu_slide_engine (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Instruction queue
  input  sldu_insn_pkg::sldu_insn_t                   issue_insn_i,
  input  logic                                        issue_valid_i,
  output logic                                        issue_done_o,
  // Lane operands
  input  sldu_lane_pkg::elen_t [`SLDU_NR_LANES-1:0]   operand_i,
  input  logic                 [`SLDU_NR_LANES-1:0]   operand_valid_i,
  output logic                 [`SLDU_NR_LANES-1:0]   operand_ready_o,
  // Result queue push
  input  logic                                        rq_full_i,
  output logic                                        rq_push_o,
  output sldu_lane_pkg::elen_t [`SLDU_NR_LANES-1:0]   rq_wdata_o,
  output sldu_lane_pkg::strb_t [`SLDU_NR_LANES-1:0]   rq_be_o,
  output sldu_lane_pkg::vaddr_t                       rq_addr_o,
  output sldu_insn_pkg::vid_t                         rq_id_o
);
  import sldu_insn_pkg::*;
  import sldu_lane_pkg::*;

  localparam int unsigned WordBytes = `SLDU_WORD_BYTES;
  localparam int unsigned PntW      = $clog2(WordBytes) + 1;

  slide_state_e              state_d, state_q;
  // Byte pointers, WordBytes means used up
  logic [PntW-1:0]           in_pnt_d, in_pnt_q;
  logic [PntW-1:0]           out_pnt_d, out_pnt_q;
  logic [PntW-1:0]           step_cnt;
  vaddr_t                    vrf_pnt_d, vrf_pnt_q;
  // Bytes still to issue for this instruction
  byte_cnt_t                 issue_cnt_d, issue_cnt_q;
  // Destination word under construction
  logic [WordBytes-1:0][7:0] word_d, word_q;
  logic [WordBytes-1:0]      be_d, be_q;
  logic [WordBytes-1:0][7:0] in_bytes;
  logic                      step, last;

  // Byte b sits in lane b/8 at offset b%8
  assign in_bytes = operand_i;

  // Advance only with all lanes valid and room downstream
  assign step     = (state_q == SLIDE_RUN) && (&operand_valid_i) && !rq_full_i;
  assign step_cnt = (in_pnt_q > out_pnt_q) ? PntW'(WordBytes) - in_pnt_q
                                           : PntW'(WordBytes) - out_pnt_q;
  assign last     = (issue_cnt_q <= byte_cnt_t'(step_cnt));

  assign rq_addr_o = vrf_pnt_q;
  assign rq_id_o   = issue_insn_i.id;

  always_comb begin
    state_d     = state_q;
    in_pnt_d    = in_pnt_q;
    out_pnt_d   = out_pnt_q;
    vrf_pnt_d   = vrf_pnt_q;
    issue_cnt_d = issue_cnt_q;
    word_d      = word_q;
    be_d        = be_q;

    operand_ready_o = '0;
    issue_done_o    = 1'b0;
    rq_push_o       = 1'b0;
    rq_wdata_o      = word_q;
    rq_be_o         = be_q;

    case (state_q)
      ////////////////////////////////////////
      SLIDE_IDLE: begin
        // Load pointers and byte count for the next instruction
        if (issue_valid_i) begin
          state_d     = SLIDE_RUN;
          issue_cnt_d = byte_cnt_t'(issue_insn_i.vl) << issue_insn_i.vsew;
          vrf_pnt_d   = vaddr_t'(issue_insn_i.vd * `SLDU_WORDS_PER_REG);
          if (issue_insn_i.op == VSLIDEUP) begin
            // Read from the start, write from the offset
            in_pnt_d    = '0;
            out_pnt_d   = PntW'(issue_insn_i.stride % WordBytes);
            issue_cnt_d = issue_cnt_d - byte_cnt_t'(issue_insn_i.stride);
            vrf_pnt_d   = vrf_pnt_d + vaddr_t'(issue_insn_i.stride / WordBytes);
          end else begin
            // Lanes start at the right word, skip the bytes below the offset
            in_pnt_d  = PntW'(issue_insn_i.stride % WordBytes);
            out_pnt_d = '0;
          end
        end
      end

      ////////////////////////////////////////
      SLIDE_RUN: begin
        if (step) begin
          // Copy the overlapping bytes, capped by what is left to issue
          for (int b = 0; b < WordBytes; b++) begin
            if (b < int'(step_cnt) && b < int'(issue_cnt_q)) begin
              word_d[int'(out_pnt_q) + b] = in_bytes[int'(in_pnt_q) + b];
              be_d[int'(out_pnt_q) + b]   = 1'b1;
            end
          end
          in_pnt_d    = in_pnt_q + step_cnt;
          out_pnt_d   = out_pnt_q + step_cnt;
          issue_cnt_d = issue_cnt_q - byte_cnt_t'(step_cnt);

          // Operand used up, release it on all lanes
          if (in_pnt_d == PntW'(WordBytes) || last) begin
            in_pnt_d        = '0;
            operand_ready_o = '1;
          end

          // Destination word complete
          if (out_pnt_d == PntW'(WordBytes) || last) begin
            out_pnt_d  = '0;
            rq_push_o  = 1'b1;
            rq_wdata_o = word_d;
            rq_be_o    = be_d;
            be_d       = '0;
            vrf_pnt_d  = vrf_pnt_q + 1'b1;
          end

          if (last) begin
            state_d      = SLIDE_IDLE;
            issue_done_o = 1'b1;
          end
        end
      end

      default: state_d = SLIDE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    word_q <= word_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= SLIDE_IDLE;
      in_pnt_q    <= '0;
      out_pnt_q   <= '0;
      vrf_pnt_q   <= '0;
      issue_cnt_q <= '0;
      be_q        <= '0;
    end else begin
      state_q     <= state_d;
      in_pnt_q    <= in_pnt_d;
      out_pnt_q   <= out_pnt_d;
      vrf_pnt_q   <= vrf_pnt_d;
      issue_cnt_q <= issue_cnt_d;
      be_q        <= be_d;
    end
  end

endmodule

/* src/sldu_result_queue.sv */
/*
 * Result queue between the slide engine and the lane writeback.
 * Circular buffer of lane-wide words, each with its strobes, VRF address
 * and instruction id. A pushed word shows at the head on the next cycle.
 */
`timescale 1ns/10ps
`include "sldu_defines.svh"

module sldu_result_queue (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Push side
  input  logic                                        rq_push_i,
  input  sldu_lane_pkg::elen_t [`SLDU_NR_LANES-1:0]   rq_wdata_i,
  input  sldu_lane_pkg::strb_t [`SLDU_NR_LANES-1:0]   rq_be_i,
  input  sldu_lane_pkg::vaddr_t                       rq_addr_i,
  input  sldu_insn_pkg::vid_t                         rq_id_i,
  output logic                                        rq_full_o,
  // Head
  output logic                                        rq_valid_o,
  output sldu_lane_pkg::elen_t [`SLDU_NR_LANES-1:0]   rq_wdata_o,
  output sldu_lane_pkg::strb_t [`SLDU_NR_LANES-1:0]   rq_be_o,
  output sldu_lane_pkg::vaddr_t                       rq_addr_o,
  output sldu_insn_pkg::vid_t                         rq_id_o,
  input  logic                                        rq_pop_i
);
  import sldu_insn_pkg::*;
  import sldu_lane_pkg::*;

  localparam int unsigned Depth = `SLDU_RESULT_QUEUE_DEPTH;
  localparam int unsigned PntW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth) + 1;

  // Payload storage
  elen_t [`SLDU_NR_LANES-1:0] wdata_q [Depth];
  strb_t [`SLDU_NR_LANES-1:0] be_q    [Depth];
  vaddr_t                     addr_q  [Depth];
  vid_t                       id_q    [Depth];

  logic [PntW-1:0] wr_pnt_q, rd_pnt_q;
  logic [CntW-1:0] cnt_q;

  assign rq_full_o  = (cnt_q == CntW'(Depth));
  assign rq_valid_o = (cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (rq_push_i) begin
      wdata_q[wr_pnt_q] <= rq_wdata_i;
      be_q[wr_pnt_q]    <= rq_be_i;
      addr_q[wr_pnt_q]  <= rq_addr_i;
      id_q[wr_pnt_q]    <= rq_id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (rq_push_i) begin
        wr_pnt_q <= (wr_pnt_q == PntW'(Depth - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (rq_pop_i) begin
        rd_pnt_q <= (rd_pnt_q == PntW'(Depth - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + CntW'(rq_push_i) - CntW'(rq_pop_i);
    end
  end

  // Head payload
  assign rq_wdata_o = wdata_q[rd_pnt_q];
  assign rq_be_o    = be_q[rd_pnt_q];
  assign rq_addr_o  = addr_q[rd_pnt_q];
  assign rq_id_o    = id_q[rd_pnt_q];

endmodule

/* src/sldu_lane_writeback.sv */
/*
 * Lane writeback of the slide unit.
 * Presents the head result word to every lane and tracks one grant per lane.
 * Pops the head once all lanes have taken it, counts the bytes left to commit
 * and signals completion of the committing instruction.
 */
`timescale 1ns/10ps
`include "sldu_defines.svh"

module sldu_lane_writeback (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Result queue head
  input  logic                                        rq_valid_i,
  input  sldu_lane_pkg::elen_t [`SLDU_NR_LANES-1:0]   rq_wdata_i,
  input  sldu_lane_pkg::strb_t [`SLDU_NR_LANES-1:0]   rq_be_i,
  input  sldu_lane_pkg::vaddr_t                       rq_addr_i,
  input  sldu_insn_pkg::vid_t                         rq_id_i,
  output logic                                        rq_pop_o,
  input  logic                                        rq_push_i,
  // Commit
  input  sldu_insn_pkg::sldu_insn_t                   commit_insn_i,
  input  logic                                        commit_valid_i,
  output logic                                        commit_done_o,
  // Lane writes
  output logic                 [`SLDU_NR_LANES-1:0]   result_req_o,
  output sldu_insn_pkg::vid_t  [`SLDU_NR_LANES-1:0]   result_id_o,
  output sldu_lane_pkg::vaddr_t [`SLDU_NR_LANES-1:0]  result_addr_o,
  output sldu_lane_pkg::elen_t [`SLDU_NR_LANES-1:0]   result_wdata_o,
  output sldu_lane_pkg::strb_t [`SLDU_NR_LANES-1:0]   result_be_o,
  input  logic                 [`SLDU_NR_LANES-1:0]   result_gnt_i,
  // Sequencer
  output logic                 [`SLDU_NR_VINSN-1:0]   vinsn_done_o
);
  import sldu_insn_pkg::*;
  import sldu_lane_pkg::*;

  localparam int unsigned WordBytes = `SLDU_WORD_BYTES;

  // Lanes that still owe a grant for the head word
  logic [`SLDU_NR_LANES-1:0] pend_q;
  byte_cnt_t                 commit_bytes, cnt_cur, cnt_q;
  logic                      loaded_q;
  logic [`SLDU_NR_VINSN-1:0] done_q;

  ////////////////////////////////////////
  // Lane requests

  assign result_req_o   = {`SLDU_NR_LANES{rq_valid_i}} & pend_q;
  assign result_id_o    = {`SLDU_NR_LANES{rq_id_i}};
  assign result_addr_o  = {`SLDU_NR_LANES{rq_addr_i}};
  assign result_wdata_o = rq_wdata_i;
  assign result_be_o    = rq_be_i;

  // Hold the pop while the finished instruction retires
  assign rq_pop_o = rq_valid_i & ~(|pend_q) & ~commit_done_o;

  ////////////////////////////////////////
  // Commit byte count

  // Slide-up words start at the aligned word holding the offset
  assign commit_bytes = (commit_insn_i.op == VSLIDEUP)
    ? (byte_cnt_t'(commit_insn_i.vl) << commit_insn_i.vsew)
      - (byte_cnt_t'(commit_insn_i.stride) & ~byte_cnt_t'(WordBytes - 1))
    : (byte_cnt_t'(commit_insn_i.vl) << commit_insn_i.vsew);
  assign cnt_cur       = loaded_q ? cnt_q : commit_bytes;
  assign commit_done_o = commit_valid_i & loaded_q & (cnt_q == '0);
  assign vinsn_done_o  = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q   <= '0;
      cnt_q    <= '0;
      loaded_q <= 1'b0;
      done_q   <= '0;
    end else begin
      // Arm all lanes when a new word reaches the head
      if (rq_pop_o || (rq_push_i && !rq_valid_i)) begin
        pend_q <= '1;
      end else begin
        pend_q <= pend_q & ~result_gnt_i;
      end

      done_q <= '0;
      if (commit_done_o) begin
        loaded_q              <= 1'b0;
        done_q[commit_insn_i.id] <= 1'b1;
      end else if (commit_valid_i) begin
        loaded_q <= 1'b1;
        // Saturate at zero on the last, partial word
        if (rq_pop_o) begin
          cnt_q <= (cnt_cur > byte_cnt_t'(WordBytes)) ? cnt_cur - byte_cnt_t'(WordBytes) : '0;
        end else begin
          cnt_q <= cnt_cur;
        end
      end
    end
  end

endmodule

/* src/sldu_top.sv */
/*
 * Vector slide unit top level.
 * Connects the instruction queue, the slide engine, the result queue and
 * the lane writeback. Takes slide-up and slide-down instructions from the
 * sequencer and source words from all lanes, writes shifted words back.
 */
`timescale 1ns/10ps
`include "sldu_defines.svh"

module sldu_top (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Sequencer
  input  sldu_insn_pkg::sldu_insn_t                   insn_i,
  input  logic                                        insn_valid_i,
  output logic                                        insn_ready_o,
  output logic                 [`SLDU_NR_VINSN-1:0]   vinsn_done_o,
  // Lane operands
  input  sldu_lane_pkg::elen_t [`SLDU_NR_LANES-1:0]   operand_i,
  input  logic                 [`SLDU_NR_LANES-1:0]   operand_valid_i,
  output logic                 [`SLDU_NR_LANES-1:0]   operand_ready_o,
  // Lane writes
  output logic                 [`SLDU_NR_LANES-1:0]   result_req_o,
  output sldu_insn_pkg::vid_t  [`SLDU_NR_LANES-1:0]   result_id_o,
  output sldu_lane_pkg::vaddr_t [`SLDU_NR_LANES-1:0]  result_addr_o,
  output sldu_lane_pkg::elen_t [`SLDU_NR_LANES-1:0]   result_wdata_o,
  output sldu_lane_pkg::strb_t [`SLDU_NR_LANES-1:0]   result_be_o,
  input  logic                 [`SLDU_NR_LANES-1:0]   result_gnt_i
);
  import sldu_insn_pkg::*;
  import sldu_lane_pkg::*;

  // Queue to engine and writeback
  sldu_insn_t issue_insn, commit_insn;
  logic       issue_valid, issue_done;
  logic       commit_valid, commit_done;

  // Engine to result queue
  logic                       rq_push, rq_full;
  elen_t [`SLDU_NR_LANES-1:0] rq_wdata;
  strb_t [`SLDU_NR_LANES-1:0] rq_be;
  vaddr_t                     rq_addr;
  vid_t                       rq_id;

  // Result queue head to writeback
  logic                       rq_valid, rq_pop;
  elen_t [`SLDU_NR_LANES-1:0] rq_head_wdata;
  strb_t [`SLDU_NR_LANES-1:0] rq_head_be;
  vaddr_t                     rq_head_addr;
  vid_t                       rq_head_id;

  sldu_insn_queue i_insn_queue (
    .clk_i, .rst_ni,
    .insn_i, .insn_valid_i, .insn_ready_o,
    .issue_insn_o   (issue_insn),
    .issue_valid_o  (issue_valid),
    .issue_done_i   (issue_done),
    .commit_insn_o  (commit_insn),
    .commit_valid_o (commit_valid),
    .commit_done_i  (commit_done)
  );

  sldu_slide_engine i_slide_engine (
    .clk_i, .rst_ni,
    .issue_insn_i  (issue_insn),
    .issue_valid_i (issue_valid),
    .issue_done_o  (issue_done),
    .operand_i, .operand_valid_i, .operand_ready_o,
    .rq_full_i     (rq_full),
    .rq_push_o     (rq_push),
    .rq_wdata_o    (rq_wdata),
    .rq_be_o       (rq_be),
    .rq_addr_o     (rq_addr),
    .rq_id_o       (rq_id)
  );

  sldu_result_queue i_result_queue (
    .clk_i, .rst_ni,
    .rq_push_i  (rq_push),
    .rq_wdata_i (rq_wdata),
    .rq_be_i    (rq_be),
    .rq_addr_i  (rq_addr),
    .rq_id_i    (rq_id),
    .rq_full_o  (rq_full),
    .rq_valid_o (rq_valid),
    .rq_wdata_o (rq_head_wdata),
    .rq_be_o    (rq_head_be),
    .rq_addr_o  (rq_head_addr),
    .rq_id_o    (rq_head_id),
    .rq_pop_i   (rq_pop)
  );

  sldu_lane_writeback i_lane_writeback (
    .clk_i, .rst_ni,
    .rq_valid_i     (rq_valid),
    .rq_wdata_i     (rq_head_wdata),
    .rq_be_i        (rq_head_be),
    .rq_addr_i      (rq_head_addr),
    .rq_id_i        (rq_head_id),
    .rq_pop_o       (rq_pop),
    .rq_push_i      (rq_push),
    .commit_insn_i  (commit_insn),
    .commit_valid_i (commit_valid),
    .commit_done_o  (commit_done),
    .result_req_o, .result_id_o, .result_addr_o,
    .result_wdata_o, .result_be_o, .result_gnt_i,
    .vinsn_done_o
  );

endmodule

/* verification/sldu_props.sv */
/*
 * Concurrent assertions for the slide unit, bound into the top level.
 * Covers lane request stability, operand handshake, done encoding and
 * result queue overflow.
 */
`timescale 1ns/10ps
`include "sldu_defines.svh"

module sldu_props (
  input logic                                        clk_i,
  input logic                                        rst_ni,
  input logic                 [`SLDU_NR_LANES-1:0]   result_req_i,
  input logic                 [`SLDU_NR_LANES-1:0]   result_gnt_i,
  input sldu_lane_pkg::elen_t [`SLDU_NR_LANES-1:0]   result_wdata_i,
  input sldu_lane_pkg::strb_t [`SLDU_NR_LANES-1:0]   result_be_i,
  input sldu_lane_pkg::vaddr_t [`SLDU_NR_LANES-1:0]  result_addr_i,
  input logic                 [`SLDU_NR_LANES-1:0]   operand_valid_i,
  input logic                 [`SLDU_NR_LANES-1:0]   operand_ready_i,
  input logic                 [`SLDU_NR_VINSN-1:0]   vinsn_done_i,
  input logic                                        rq_push_i,
  input logic                                        rq_full_i
);

  // A lane request and its payload hold until that lane grants
  for (genvar l = 0; l < `SLDU_NR_LANES; l++) begin : g_lane
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_i[l] && !result_gnt_i[l] |=> result_req_i[l]
        && $stable(result_wdata_i[l]) && $stable(result_be_i[l])
        && $stable(result_addr_i[l]))
      else $error("lane %0d request changed before its grant", l);
  end

  // Operands are only released when every lane offers one
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_ready_i != '0) |-> (&operand_valid_i))
    else $error("operand ready without all lanes valid");

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(vinsn_done_i))
    else $error("more than one done bit set");

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(rq_push_i && rq_full_i))
    else $error("result queue pushed while full");

endmodule

bind sldu_top sldu_props i_props (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .result_req_i    (result_req_o),
  .result_gnt_i    (result_gnt_i),
  .result_wdata_i  (result_wdata_o),
  .result_be_i     (result_be_o),
  .result_addr_i   (result_addr_o),
  .operand_valid_i (operand_valid_i),
  .operand_ready_i (operand_ready_o),
  .vinsn_done_i    (vinsn_done_o),
  .rq_push_i       (rq_push),
  .rq_full_i       (rq_full)
);

/* verification/sldu_tb.sv */
/*
 * Testbench of the vector slide unit.
 * Sends the rows of a stimulus table to the DUT, feeds source words from a
 * random register image per row, grants lane writes at random and checks
 * every granted byte against a reference built from the slide rules.
 */
`timescale 1ns/10ps
`include "sldu_defines.svh"

module sldu_tb;
  import sldu_insn_pkg::*;
  import sldu_lane_pkg::*;

  localparam int NRows   = 8;
  localparam int Lanes   = `SLDU_NR_LANES;
  localparam int WB      = `SLDU_WORD_BYTES;
  localparam int Timeout = 2000 * NRows + 20;

  // Op 0 is up and op 1 is down, vsew is log2 of the byte count
  // Vl and stride count elements
  // Chain sends the next row at once and hold withholds grants
  typedef struct {
    int op;
    int vsew;
    int vl;
    int stride;
    int vd;
    int chain;
    int hold;
  } row_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  sldu_insn_t insn_i;
  logic insn_valid_i, insn_ready_o;
  logic [`SLDU_NR_VINSN-1:0] vinsn_done_o;
  elen_t [Lanes-1:0] operand_i;
  logic [Lanes-1:0] operand_valid_i, operand_ready_o;
  logic [Lanes-1:0] result_req_o, result_gnt_i;
  vid_t [Lanes-1:0] result_id_o;
  vaddr_t [Lanes-1:0] result_addr_o;
  elen_t [Lanes-1:0] result_wdata_o;
  strb_t [Lanes-1:0] result_be_o;

  row_t tbl [NRows];
  logic [7:0] src_mem [NRows][256];
  int sent [NRows];
  int done_cnt [NRows];
  int bytes_seen [NRows];
  int err_row [NRows];
  int errors, tests_pass, tests_fail, cycles;
  int feed_q [$];
  int feed_row, feed_word, feed_left;
  bit feed_active, hold_gnt;

  sldu_top i_dut (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Reference rules

  function automatic int stride_bytes(input int r);
    return tbl[r].stride << tbl[r].vsew;
  endfunction

  function automatic int total_bytes(input int r);
    return tbl[r].vl << tbl[r].vsew;
  endfunction

  // Slide-up leaves the bytes below the offset untouched
  function automatic int written_bytes(input int r);
    return (tbl[r].op == 0) ? total_bytes(r) - stride_bytes(r) : total_bytes(r);
  endfunction

  function automatic int first_src_word(input int r);
    return (tbl[r].op == 0) ? 0 : stride_bytes(r) / WB;
  endfunction

  // Source words the unit consumes from the first fed byte on
  function automatic int src_words(input int r);
    int span;
    span = (tbl[r].op == 0) ? written_bytes(r) : stride_bytes(r) % WB + total_bytes(r);
    return (span + WB - 1) / WB;
  endfunction

  function automatic logic [7:0] ref_byte(input int r, input int d);
    return (tbl[r].op == 0) ? src_mem[r][d - stride_bytes(r)] : src_mem[r][d + stride_bytes(r)];
  endfunction

  task automatic count_error(input int r);
    errors++;
    if (r >= 0) err_row[r]++;
  endtask

  task automatic send_insn(input int r);
    sldu_insn_t insn;
    insn.id     = vid_t'(r);
    insn.op     = (tbl[r].op == 0) ? VSLIDEUP : VSLIDEDOWN;
    insn.vsew   = vsew_e'(tbl[r].vsew);
    insn.vl     = tbl[r].vl;
    insn.stride = tbl[r].stride;
    insn.vd     = tbl[r].vd;
    @(posedge clk_i);
    insn_i       <= insn;
    insn_valid_i <= 1'b1;
    do @(posedge clk_i); while (!insn_ready_o);
    insn_valid_i <= 1'b0;
    sent[r] = 1;
    feed_q.push_back(r);
  endtask

  ////////////////////////////////////////
  // Lane feeder presents one source word per operand ready pulse

  always @(posedge clk_i) begin
    logic [WB*8-1:0] flat;
    if (feed_active && operand_ready_o[0]) begin
      feed_word++;
      feed_left--;
      if (feed_left == 0) feed_active = 0;
    end
    if (!feed_active && feed_q.size() > 0) begin
      feed_row    = feed_q.pop_front();
      feed_word   = first_src_word(feed_row);
      feed_left   = src_words(feed_row);
      feed_active = 1;
    end
    flat = '0;
    for (int k = 0; k < WB; k++) begin
      if (feed_active) flat[k*8 +: 8] = src_mem[feed_row][feed_word*WB + k];
    end
    operand_i       <= flat;
    operand_valid_i <= feed_active ? '1 : '0;
  end

  // Random one-cycle grant per lane
  always @(posedge clk_i) begin
    for (int l = 0; l < Lanes; l++) begin
      if (result_gnt_i[l]) result_gnt_i[l] <= 1'b0;
      else if (result_req_o[l] && !hold_gnt && ($urandom % 2 == 0)) result_gnt_i[l] <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Write checker

  always @(posedge clk_i) begin
    int r, rel, d;
    logic [7:0] got;
    for (int l = 0; l < Lanes; l++) begin
      if (rst_ni && result_req_o[l] && result_gnt_i[l]) begin
        r   = int'(result_id_o[l]);
        rel = int'(result_addr_o[l]) - tbl[r].vd * `SLDU_WORDS_PER_REG;
        if (!sent[r] || done_cnt[r] != 0) begin
          $display("write on lane %0d carries id %0d of no open test", l, r);
          count_error(-1);
        end else begin
          for (int b = 0; b < 8; b++) begin
            if (result_be_o[l][b]) begin
              d   = rel * WB + l * 8 + b;
              got = result_wdata_o[l][b*8 +: 8];
              bytes_seen[r]++;
              if (d < total_bytes(r) - written_bytes(r) || d >= total_bytes(r)) begin
                $display("test %0d wrote byte %0d outside its destination range", r, d);
                count_error(r);
              end else if (got !== ref_byte(r, d)) begin
                $display("FAIL t=%0t result_wdata_o[%0d] byte %0d: got %h expected %h",
                         $time, l, d, got, ref_byte(r, d));
                count_error(r);
              end
            end
          end
        end
      end
    end
  end

  // Done monitor prints one line per finished test
  always @(posedge clk_i) begin
    if (rst_ni && vinsn_done_o != '0) begin
      for (int i = 0; i < `SLDU_NR_VINSN; i++) begin
        if (vinsn_done_o[i] && !sent[i]) begin
          $display("done pulse for id %0d, which was never sent", i);
          count_error(-1);
        end else if (vinsn_done_o[i]) begin
          done_cnt[i]++;
          if (done_cnt[i] > 1) begin
            $display("second done pulse for test %0d", i);
            count_error(i);
          end
          if (bytes_seen[i] != written_bytes(i)) begin
            $display("test %0d wrote %0d bytes, expected %0d", i, bytes_seen[i],
                     written_bytes(i));
            count_error(i);
          end
          if (err_row[i] == 0) tests_pass++;
          else tests_fail++;
          $display("test %0d (op %0d, sew %0d): %0d errors", i, tbl[i].op, 8 << tbl[i].vsew,
                   err_row[i]);
        end
      end
    end
  end

  // Run limit
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= Timeout) begin
      $display("timeout after %0d cycles, a test never completed", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Main sequence

  initial begin
    int rst_errs;
    rst_ni          = 1'b0;
    insn_i          = '0;
    insn_valid_i    = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    result_gnt_i    = '0;
    void'($urandom(76));
    tbl[0] = '{0, 3, 16, 4, 2, 0, 0};
    tbl[1] = '{1, 0, 100, 5, 3, 0, 0};
    tbl[2] = '{0, 1, 40, 3, 4, 0, 0};
    tbl[3] = '{1, 2, 20, 9, 5, 0, 0};
    // Back-to-back pair
    tbl[4] = '{0, 0, 96, 35, 6, 1, 0};
    tbl[5] = '{1, 1, 50, 20, 7, 0, 0};
    // Pair sent while no lane grants
    tbl[6] = '{0, 2, 24, 5, 1, 1, 1};
    tbl[7] = '{1, 3, 12, 3, 0, 0, 1};
    for (int r = 0; r < NRows; r++) begin
      for (int k = 0; k < 256; k++) src_mem[r][k] = 8'($urandom);
    end

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    rst_errs = errors;
    if (insn_ready_o !== 1'b1 || result_req_o !== '0 || operand_ready_o !== '0
        || vinsn_done_o !== '0) begin
      $display("outputs not idle after reset");
      count_error(-1);
    end
    if (errors == rst_errs) tests_pass++;
    else tests_fail++;
    $display("test reset: %0d errors", errors - rst_errs);

    for (int r = 0; r < NRows; r++) begin
      if (tbl[r].hold != 0) hold_gnt <= 1'b1;
      send_insn(r);
      if (tbl[r].chain == 0) begin
        if (hold_gnt) begin
          @(posedge clk_i);
          if (insn_ready_o !== 1'b0) begin
            $display("instruction queue still ready after two acceptances");
            count_error(r);
          end
          repeat (50) @(posedge clk_i);
          if (result_req_o == '0) begin
            $display("no lane write pending while grants are withheld");
            count_error(r);
          end
          hold_gnt <= 1'b0;
        end
        for (int k = 0; k <= r; k++) begin
          while (sent[k] != 0 && done_cnt[k] == 0) @(posedge clk_i);
        end
      end
    end
    repeat (5) @(posedge clk_i);

    $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+src
src/sldu_insn_pkg.sv
src/sldu_lane_pkg.sv
src/sldu_insn_queue.sv
src/sldu_slide_engine.sv
src/sldu_result_queue.sv
src/sldu_lane_writeback.sv
src/sldu_top.sv
verification/sldu_props.sv
verification/sldu_tb.sv

/* Makefile */
# Verilator build and run of the slide unit testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module sldu_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vsldu_tb | tee /dev/stderr | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
